//--- rtl/ddr_scrb_pkg.sv
// DDR geometry as seen by the scrubbers
// The scrub limit is the reduced simulation size; hardware scrubs 16 GB
// per channel, which is a last address of 64'h3_FFFF_FFFF

`default_nettype none

package ddr_scrb_pkg;

   // Four DDR channels with one scrubber each
   localparam int num_ddr = 4;

   // Byte address on a DDR channel
   typedef logic [63:0] ddr_addr_t;

   // One bit per channel for ready, enable and done
   typedef logic [num_ddr-1:0] ddr_mask_t;

   // ------------------------------------------------------------------------
   // Burst geometry
   // ------------------------------------------------------------------------

   localparam int scrb_burst_beats = 16;
   localparam int ddr_beat_bytes   = 64;

   // Address step per burst request
   localparam ddr_addr_t scrb_burst_bytes = ddr_addr_t'(scrb_burst_beats * ddr_beat_bytes);

   // Last byte address to scrub in the 8 KiB simulation size
   localparam ddr_addr_t scrb_max_addr = 64'h1FFF;

endpackage

`default_nettype wire

//--- rtl/cl_id_pkg.sv
// Host-control register map shared by the control logic and the testbench
// Bits 3 to 0 of the control word enable the scrubbers, one bit per channel
// The fixed ID words are the PCI vendor/device and subsystem IDs

`default_nettype none

package cl_id_pkg;

   // Control word from the shell and the 32-bit ID/status words back to it
   typedef logic [31:0] ctl_word_t;
   typedef logic [31:0] id_word_t;

   // ------------------------------------------------------------------------
   // Control word fields
   // ------------------------------------------------------------------------

   // Debug view of the scrub address on the ID outputs
   localparam int dbg_en_bit  = 31;

   // 3-bit channel select starting here
   localparam int dbg_sel_lsb = 28;

   typedef logic [2:0] dbg_sel_t;

   // ------------------------------------------------------------------------
   // Fixed identification
   // ------------------------------------------------------------------------

   localparam id_word_t cl_id0_value = 32'hF000_1D0F;
   localparam id_word_t cl_id1_value = 32'h1D51_FEDC;

endpackage

`default_nettype wire

//--- rtl/scrb_if.sv
// Link between the scrub controller and one channel scrubber
// aw_ready is driven from the top level by the channel's write-address ready

`timescale 1ns/100ps
`default_nettype none

interface scrb_if;
   import ddr_scrb_pkg::*;

   // Controller side
   logic      enable;

   // Scrubber side
   logic      done;
   logic      aw_valid;
   ddr_addr_t addr;

   // From the DDR write-address channel
   logic      aw_ready;

   modport ctl (
      output enable,
      input  done,
      input  addr
   );

   modport scrb (
      input  enable,
      input  aw_ready,
      output done,
      output aw_valid,
      output addr
   );

endinterface

`default_nettype wire

//--- rtl/ddr_scrubber.sv
// Walks one channel from address 0 in fixed bursts, one request per burst
// Only write-address requests are issued; no data or response channel
// done and the final address hold until enable falls

`timescale 1ns/100ps
`default_nettype none

module ddr_scrubber (
   input  logic clk,
   input  logic sync_rst_n,
   scrb_if.scrb scrb
);
   import ddr_scrb_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_req,
      st_done
   } scrb_state_t;

   scrb_state_t state_q;
   ddr_addr_t   addr_q;
   ddr_addr_t   addr_nxt;
   logic        aw_fire;
   logic        last_burst;

   assign addr_nxt   = addr_q + scrb_burst_bytes;
   assign aw_fire    = (state_q == st_req) && scrb.aw_ready;

   // Burst that steps past the scrub limit is the final one
   assign last_burst = addr_nxt > scrb_max_addr;

   // ------------------------------------------------------------------------
   // State and address
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state_q <= st_idle;
         addr_q  <= '0;
      end
      else if (!scrb.enable)
      begin
         // Dropping enable abandons any scrub in progress
         state_q <= st_idle;
         addr_q  <= '0;
      end
      else
      begin
         case (state_q)
            st_idle:
            begin
               state_q <= st_req;
            end
            st_req:
            begin
               if (aw_fire)
               begin
                  addr_q <= addr_nxt;
                  if (last_burst)
                     state_q <= st_done;
               end
            end
            st_done:
            begin
               state_q <= st_done;
            end
            default:
            begin
               state_q <= st_idle;
            end
         endcase
      end
   end

   // Request held with a stable address until accepted
   assign scrb.aw_valid = (state_q == st_req);
   assign scrb.done     = (state_q == st_done);
   assign scrb.addr     = addr_q;

endmodule

`default_nettype wire

//--- rtl/cl_scrb_ctl.sv
// Host control for the scrubbers with control word, DDR-ready capture and status
// Also produces the FLR acknowledge and the debug view on the ID outputs
// A debug select of num_ddr or more shows channel 0

`timescale 1ns/100ps
`default_nettype none

module cl_scrb_ctl (
   input  logic                    clk,
   input  logic                    sync_rst_n,
   input  cl_id_pkg::ctl_word_t    sh_cl_ctl0,
   input  ddr_scrb_pkg::ddr_mask_t sh_cl_ddr_is_ready,
   input  logic                    sh_cl_flr_assert,
   output logic                    cl_sh_flr_done,
   output cl_id_pkg::id_word_t     cl_sh_id0,
   output cl_id_pkg::id_word_t     cl_sh_id1,
   output cl_id_pkg::id_word_t     cl_sh_status0,
   scrb_if.ctl                     scrb [ddr_scrb_pkg::num_ddr]
);
   import cl_id_pkg::*;
   import ddr_scrb_pkg::*;

   ctl_word_t ctl_q;
   ddr_mask_t ready_q;
   ddr_mask_t scrb_en;
   ddr_mask_t done_mask;
   ddr_addr_t scrb_addr [num_ddr];
   logic      flr_assert_q;
   logic      dbg_en;
   dbg_sel_t  dbg_sel;
   ddr_addr_t dbg_addr;

   // ------------------------------------------------------------------------
   // Input capture
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q   <= '0;
         ready_q <= '0;
      end
      else
      begin
         ctl_q   <= sh_cl_ctl0;
         ready_q <= sh_cl_ddr_is_ready;
      end
   end

   // A channel scrubs only once its controller reports ready
   assign scrb_en = ctl_q[num_ddr-1:0] & ready_q;

   for (genvar i = 0; i < num_ddr; i++)
   begin : g_chan
      assign scrb[i].enable = scrb_en[i];
      assign done_mask[i]   = scrb[i].done;
      assign scrb_addr[i]   = scrb[i].addr;
   end

   // ------------------------------------------------------------------------
   // Status and FLR acknowledge
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         cl_sh_status0  <= '0;
         flr_assert_q   <= 1'b0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         cl_sh_status0  <= id_word_t'(done_mask);
         flr_assert_q   <= sh_cl_flr_assert;
         // Toggles while assert is held so it is never high two cycles in a row
         cl_sh_flr_done <= flr_assert_q && !cl_sh_flr_done;
      end
   end

   // ------------------------------------------------------------------------
   // Debug ID mux
   // ------------------------------------------------------------------------
   assign dbg_en  = ctl_q[dbg_en_bit];
   assign dbg_sel = ctl_q[dbg_sel_lsb +: $bits(dbg_sel_t)];

   always_comb
   begin
      dbg_addr = scrb_addr[0];
      for (int i = 1; i < num_ddr; i++)
      begin
         if (dbg_sel == dbg_sel_t'(i))
            dbg_addr = scrb_addr[i];
      end
   end

   always_ff @(posedge clk)
   begin
      if (dbg_en)
      begin
         cl_sh_id0 <= dbg_addr[31:0];
         cl_sh_id1 <= dbg_addr[63:32];
      end
      else
      begin
         cl_sh_id0 <= cl_id0_value;
         cl_sh_id1 <= cl_id1_value;
      end
   end

endmodule

`default_nettype wire

//--- rtl/cl_dram_scrb_top.sv
// Scrubbing and host-control top with one controller and one scrubber per channel
// Reset is taken directly; any synchronization happens outside this block
// Only write-address requests leave the block, with INCR bursts implied

`timescale 1ns/100ps
`default_nettype none

module cl_dram_scrb_top (
   input  logic                    clk,
   input  logic                    sync_rst_n,

   // Shell control and status
   input  cl_id_pkg::ctl_word_t    sh_cl_ctl0,
   input  ddr_scrb_pkg::ddr_mask_t sh_cl_ddr_is_ready,
   input  logic                    sh_cl_flr_assert,
   output logic                    cl_sh_flr_done,
   output cl_id_pkg::id_word_t     cl_sh_id0,
   output cl_id_pkg::id_word_t     cl_sh_id1,
   output cl_id_pkg::id_word_t     cl_sh_status0,

   // Per-channel write-address requests
   output ddr_scrb_pkg::ddr_mask_t cl_sh_ddr_awvalid,
   input  ddr_scrb_pkg::ddr_mask_t sh_cl_ddr_awready,
   output ddr_scrb_pkg::ddr_addr_t cl_sh_ddr_awaddr [ddr_scrb_pkg::num_ddr]
);
   import ddr_scrb_pkg::*;

   scrb_if scrb_bus [num_ddr] ();

   // ------------------------------------------------------------------------
   // Controller
   // ------------------------------------------------------------------------
   cl_scrb_ctl u_ctl (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .cl_sh_flr_done     (cl_sh_flr_done),
      .cl_sh_id0          (cl_sh_id0),
      .cl_sh_id1          (cl_sh_id1),
      .cl_sh_status0      (cl_sh_status0),
      .scrb               (scrb_bus)
   );

   // ------------------------------------------------------------------------
   // Scrubbers with channel i on bit and element i of the request ports
   // ------------------------------------------------------------------------
   for (genvar i = 0; i < num_ddr; i++)
   begin : g_scrb
      assign scrb_bus[i].aw_ready = sh_cl_ddr_awready[i];
      assign cl_sh_ddr_awvalid[i] = scrb_bus[i].aw_valid;
      assign cl_sh_ddr_awaddr[i]  = scrb_bus[i].addr;

      ddr_scrubber u_scrb (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .scrb       (scrb_bus[i])
      );
   end

endmodule

`default_nettype wire

//--- tb/cl_scrb_sva.sv
// Protocol checks bound to the scrubbing top level
// Each channel's request handshake is checked on its own

`timescale 1ns/100ps
`default_nettype none

module cl_scrb_sva (
   input logic                    clk,
   input logic                    sync_rst_n,
   input logic                    cl_sh_flr_done,
   input cl_id_pkg::id_word_t     cl_sh_status0,
   input ddr_scrb_pkg::ddr_mask_t cl_sh_ddr_awvalid,
   input ddr_scrb_pkg::ddr_mask_t sh_cl_ddr_awready,
   input ddr_scrb_pkg::ddr_addr_t cl_sh_ddr_awaddr [ddr_scrb_pkg::num_ddr]
);
   import ddr_scrb_pkg::*;

   // FLR acknowledge is a single-cycle pulse
   a_flr_pulse: assert property (@(posedge clk) disable iff (!sync_rst_n)
      cl_sh_flr_done |=> !cl_sh_flr_done)
      else $error("FLR acknowledge high on two consecutive cycles");

   for (genvar i = 0; i < num_ddr; i++)
   begin : g_chan
      // Request held with a stable address until accepted
      a_aw_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
         cl_sh_ddr_awvalid[i] && !sh_cl_ddr_awready[i]
         |=> cl_sh_ddr_awvalid[i] && $stable(cl_sh_ddr_awaddr[i]))
         else $error("channel %0d dropped or changed a pending request", i);

      a_no_req_done: assert property (@(posedge clk) disable iff (!sync_rst_n)
         !(cl_sh_ddr_awvalid[i] && cl_sh_status0[i]))
         else $error("channel %0d requests while reported done", i);
   end

endmodule

bind cl_dram_scrb_top cl_scrb_sva u_sva (
   .clk               (clk),
   .sync_rst_n        (sync_rst_n),
   .cl_sh_flr_done    (cl_sh_flr_done),
   .cl_sh_status0     (cl_sh_status0),
   .cl_sh_ddr_awvalid (cl_sh_ddr_awvalid),
   .sh_cl_ddr_awready (sh_cl_ddr_awready),
   .cl_sh_ddr_awaddr  (cl_sh_ddr_awaddr)
);

`default_nettype wire

//--- tb/tb_cl_dram_scrb.sv
// Directed testbench for the scrubbing and host-control top
// Expected scrub walk assumes the reduced simulation limit of 8 KiB per channel
// Stops at the first mismatch or timeout

`timescale 1ns/100ps
`default_nettype none

module tb_cl_dram_scrb;
   import cl_id_pkg::*;
   import ddr_scrb_pkg::*;

   // Expected walk is 8 bursts of 1 KiB ending at 0x2000
   localparam ddr_addr_t burst_step    = 64'h400;
   localparam int        num_bursts    = 8;
   localparam int        scrub_timeout = 400;
   localparam id_word_t  exp_id0       = 32'hF000_1D0F;
   localparam id_word_t  exp_id1       = 32'h1D51_FEDC;

   logic        clk;
   logic        sync_rst_n;
   ctl_word_t   sh_cl_ctl0;
   ddr_mask_t   sh_cl_ddr_is_ready;
   logic        sh_cl_flr_assert;
   logic        cl_sh_flr_done;
   id_word_t    cl_sh_id0;
   id_word_t    cl_sh_id1;
   id_word_t    cl_sh_status0;
   ddr_mask_t   cl_sh_ddr_awvalid;
   ddr_mask_t   sh_cl_ddr_awready;
   ddr_addr_t   cl_sh_ddr_awaddr [num_ddr];
   int unsigned rnd_seed;

   cl_dram_scrb_top dut0 (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .cl_sh_flr_done     (cl_sh_flr_done),
      .cl_sh_id0          (cl_sh_id0),
      .cl_sh_id1          (cl_sh_id1),
      .cl_sh_status0      (cl_sh_status0),
      .cl_sh_ddr_awvalid  (cl_sh_ddr_awvalid),
      .sh_cl_ddr_awready  (sh_cl_ddr_awready),
      .cl_sh_ddr_awaddr   (cl_sh_ddr_awaddr)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   // -------------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------------
   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic check(input string what, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (actual !== expected)
         stop_with_failure($sformatf("error: %0t ns: %s expected %0h, got %0h",
                                     $time, what, expected, actual));
   endtask

   // Inputs change and outputs are sampled 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Enables the channels in en_mask and follows every request to completion
   task automatic scrub_and_check(input ddr_mask_t en_mask, input bit random_ready);
      int        req_cnt [num_ddr];
      int        cycles;
      ddr_mask_t ready_now;
      for (int ch = 0; ch < num_ddr; ch++)
         req_cnt[ch] = 0;
      sh_cl_ctl0 = ctl_word_t'(en_mask);
      cycles = 0;
      while (cl_sh_status0[num_ddr-1:0] != en_mask)
      begin
         if (cycles == scrub_timeout)
            stop_with_failure("timeout: scrub did not reach the expected done flags");
         next_cycle();
         cycles++;
         ready_now = random_ready ? ddr_mask_t'($urandom) : '1;
         sh_cl_ddr_awready = ready_now;
         for (int ch = 0; ch < num_ddr; ch++)
         begin
            if (!en_mask[ch])
               check($sformatf("awvalid on idle channel %0d", ch), 64'h0,
                     64'(cl_sh_ddr_awvalid[ch]));
            // Valid and ready both high here means a transfer at the next edge
            if (cl_sh_ddr_awvalid[ch] && ready_now[ch])
            begin
               if (req_cnt[ch] >= num_bursts)
                  stop_with_failure($sformatf("channel %0d issued too many requests", ch));
               check($sformatf("channel %0d request address", ch),
                     64'(req_cnt[ch]) * burst_step, cl_sh_ddr_awaddr[ch]);
               req_cnt[ch]++;
            end
         end
      end
      for (int ch = 0; ch < num_ddr; ch++)
      begin
         if (en_mask[ch])
         begin
            check($sformatf("channel %0d request count", ch), 64'(num_bursts),
                  64'(req_cnt[ch]));
            check($sformatf("channel %0d final address", ch),
                  64'(num_bursts) * burst_step, cl_sh_ddr_awaddr[ch]);
         end
      end
      check("awvalid after done", 64'h0, 64'(cl_sh_ddr_awvalid));
      check("status after scrub", 64'(en_mask), 64'(cl_sh_status0));
   endtask

   // Drops every enable and waits for status and addresses to return to zero
   task automatic clear_scrub();
      int cycles;
      sh_cl_ctl0 = '0;
      cycles = 0;
      while (cl_sh_status0 != '0)
      begin
         if (cycles == 10)
            stop_with_failure("timeout: status did not clear after disable");
         next_cycle();
         cycles++;
      end
      for (int ch = 0; ch < num_ddr; ch++)
         check($sformatf("channel %0d address after clear", ch), 64'h0,
               cl_sh_ddr_awaddr[ch]);
      check("awvalid after clear", 64'h0, 64'(cl_sh_ddr_awvalid));
   endtask

   // -------------------------------------------------------------------------
   // Tests
   // -------------------------------------------------------------------------
   task automatic test_reset_state();
      check("awvalid after reset", 64'h0, 64'(cl_sh_ddr_awvalid));
      check("flr_done after reset", 64'h0, 64'(cl_sh_flr_done));
      check("status after reset", 64'h0, 64'(cl_sh_status0));
      check("id0 after reset", 64'(exp_id0), 64'(cl_sh_id0));
      check("id1 after reset", 64'(exp_id1), 64'(cl_sh_id1));
      for (int ch = 0; ch < num_ddr; ch++)
         check($sformatf("channel %0d address after reset", ch), 64'h0,
               cl_sh_ddr_awaddr[ch]);
   endtask

   task automatic test_flr_ack();
      int pulses;
      pulses = 0;
      sh_cl_flr_assert = 1'b1;
      next_cycle();
      sh_cl_flr_assert = 1'b0;
      for (int c = 0; c < 8; c++)
      begin
         next_cycle();
         if (cl_sh_flr_done)
            pulses++;
      end
      check("flr_done pulse count", 64'h1, 64'(pulses));
      // Held assert acknowledges on every other cycle
      sh_cl_flr_assert = 1'b1;
      for (int c = 0; c < 8; c++)
      begin
         next_cycle();
         check($sformatf("flr_done while held, cycle %0d", c), 64'(c % 2),
               64'(cl_sh_flr_done));
      end
      sh_cl_flr_assert = 1'b0;
      repeat (2) next_cycle();
      check("flr_done after release", 64'h0, 64'(cl_sh_flr_done));
   endtask

   task automatic test_single_channel();
      sh_cl_ddr_awready = '1;
      scrub_and_check(4'b0100, 1'b0);
      clear_scrub();
   endtask

   task automatic test_back_pressure();
      scrub_and_check(4'b1111, 1'b1);
      clear_scrub();
   endtask

   task automatic test_ready_gating();
      sh_cl_ddr_is_ready = 4'b0111;
      sh_cl_ddr_awready  = '1;
      sh_cl_ctl0         = 32'h0000_0008;
      for (int c = 0; c < 20; c++)
      begin
         next_cycle();
         check("awvalid on channel 3 without ddr ready", 64'h0,
               64'(cl_sh_ddr_awvalid[3]));
      end
      sh_cl_ddr_is_ready = '1;
      scrub_and_check(4'b1000, 1'b0);
      clear_scrub();
   endtask

   task automatic test_debug_id();
      sh_cl_ddr_awready = '1;
      scrub_and_check(4'b0010, 1'b0);
      // Debug view of channel 1, which stays enabled so its address holds
      sh_cl_ctl0 = 32'h9000_0002;
      repeat (2) next_cycle();
      check("debug id0 for channel 1", 64'h2000, 64'(cl_sh_id0));
      check("debug id1 for channel 1", 64'h0, 64'(cl_sh_id1));
      sh_cl_ctl0 = 32'h8000_0002;
      repeat (2) next_cycle();
      check("debug id0 for channel 0", 64'h0, 64'(cl_sh_id0));
      check("debug id1 for channel 0", 64'h0, 64'(cl_sh_id1));
      sh_cl_ctl0 = 32'h0000_0002;
      repeat (2) next_cycle();
      check("id0 with debug off", 64'(exp_id0), 64'(cl_sh_id0));
      check("id1 with debug off", 64'(exp_id1), 64'(cl_sh_id1));
      clear_scrub();
   endtask

   initial
   begin
      rnd_seed           = $urandom(32'hcd25);
      clk                = 1'b0;
      sync_rst_n         = 1'b0;
      sh_cl_ctl0         = '0;
      sh_cl_ddr_is_ready = '1;
      sh_cl_flr_assert   = 1'b0;
      sh_cl_ddr_awready  = '0;
      repeat (2) @(posedge clk);
      #1;
      sync_rst_n = 1'b1;

      test_reset_state();
      test_flr_ack();
      test_single_channel();
      test_back_pressure();
      test_ready_gating();
      test_debug_id();

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
rtl/ddr_scrb_pkg.sv
rtl/cl_id_pkg.sv
rtl/scrb_if.sv
rtl/ddr_scrubber.sv
rtl/cl_scrb_ctl.sv
rtl/cl_dram_scrb_top.sv
tb/cl_scrb_sva.sv
tb/tb_cl_dram_scrb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the scrubber testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
   --top-module tb_cl_dram_scrb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_cl_dram_scrb 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi

echo "Pass message not found in simulation output"
exit 1
